// ==== verilog/rvv_defs.svh ====
`ifndef RVV_DEFS_SVH
`define RVV_DEFS_SVH

// data path and register file sizes
`define RVV_VLEN            64
`define RVV_NUM_VEC         32
`define RVV_XLEN            32
`define RVV_DW_B            8     // bytes per vector register
`define RVV_INSN_WIDTH      32
`define RVV_MEM_ADDR_WIDTH  32
`define RVV_REG_ADDR_WIDTH  5

// major opcodes
`define RVV_OPC_LD          7'h07
`define RVV_OPC_ST          7'h27
`define RVV_OPC_OP          7'h57

// minor types (funct3 of OP-V)
`define RVV_IVV             3'h0
`define RVV_IVI             3'h3
`define RVV_IVX             3'h4
`define RVV_CFG             3'h7

// funct6 codes
`define RVV_F6_ADD          6'h00
`define RVV_F6_SUB          6'h02
`define RVV_F6_AND          6'h09
`define RVV_F6_OR           6'h0a
`define RVV_F6_XOR          6'h0b

`endif

// ==== verilog/rvv_pkg.sv ====
`default_nettype none

`include "rvv_defs.svh"

package rvv_pkg;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_CFG
    } insn_class_e;

    typedef enum logic [2:0] {
        FN_ADD,
        FN_SUB,
        FN_AND,
        FN_OR,
        FN_XOR
    } alu_fn_e;

    // where operand 1 comes from
    typedef enum logic [1:0] {
        SRC_VV,
        SRC_VX,
        SRC_VI
    } src_kind_e;

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_e;

    typedef logic [`RVV_VLEN-1:0] vreg_t;

    typedef struct packed {
        insn_class_e                    cls;
        alu_fn_e                        fn;
        src_kind_e                      kind;
        logic [`RVV_REG_ADDR_WIDTH-1:0] dest;      // vd, or vs3 for a store
        logic [`RVV_REG_ADDR_WIDTH-1:0] src1;      // vs1, rs1 or imm
        logic [`RVV_REG_ADDR_WIDTH-1:0] src2;
        sew_e                           sew;       // vsetvli only
        logic                           rs1_zero;  // vsetvli only
    } dec_insn_t;

    typedef struct packed {
        insn_class_e                    cls;
        alu_fn_e                        fn;
        src_kind_e                      kind;
        logic [`RVV_REG_ADDR_WIDTH-1:0] dest;
        sew_e                           sew;
        vreg_t                          vs1;
        vreg_t                          vs2;       // store data for a store
        logic [`RVV_XLEN-1:0]           scalar;
        logic [`RVV_DW_B-1:0]           be;
    } exec_req_t;

endpackage

`default_nettype wire

// ==== verilog/rvv_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_defs.svh"

module rvv_decoder (
    input  wire  [`RVV_INSN_WIDTH-1:0] insn,
    output rvv_pkg::dec_insn_t         dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [5:0] funct6;
    logic       unit_whole;  // unit stride, single field

    assign opcode     = insn[6:0];
    assign funct3     = insn[14:12];
    assign funct6     = insn[31:26];
    assign unit_whole = (insn[31:29] == 3'd0) && (insn[27:26] == 2'd0);

    always_comb begin
        dec          = '0;
        dec.dest     = insn[11:7];
        dec.src1     = insn[19:15];
        dec.src2     = insn[24:20];
        dec.sew      = rvv_pkg::sew_e'(insn[24:23]);  // vsew field of vtype
        dec.rs1_zero = (insn[19:15] == 5'd0);

        case (opcode)
            `RVV_OPC_LD: if (unit_whole) dec.cls = rvv_pkg::CLS_LOAD;
            `RVV_OPC_ST: if (unit_whole) dec.cls = rvv_pkg::CLS_STORE;
            `RVV_OPC_OP: begin
                case (funct3)
                    `RVV_IVV: dec.kind = rvv_pkg::SRC_VV;
                    `RVV_IVX: dec.kind = rvv_pkg::SRC_VX;
                    default:  dec.kind = rvv_pkg::SRC_VI;
                endcase
                if (funct3 == `RVV_CFG) begin
                    if (!insn[31]) dec.cls = rvv_pkg::CLS_CFG;  // vsetvli only
                end else if (funct3 == `RVV_IVV || funct3 == `RVV_IVX ||
                             funct3 == `RVV_IVI) begin
                    dec.cls = rvv_pkg::CLS_ALU;
                    case (funct6)
                        `RVV_F6_ADD: dec.fn = rvv_pkg::FN_ADD;
                        `RVV_F6_SUB: dec.fn = rvv_pkg::FN_SUB;
                        `RVV_F6_AND: dec.fn = rvv_pkg::FN_AND;
                        `RVV_F6_OR:  dec.fn = rvv_pkg::FN_OR;
                        `RVV_F6_XOR: dec.fn = rvv_pkg::FN_XOR;
                        default:     dec.cls = rvv_pkg::CLS_NONE;  // retires as no-op
                    endcase
                end
            end
            default: dec.cls = rvv_pkg::CLS_NONE;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rvv_cfg_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_defs.svh"

module rvv_cfg_unit (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    cfg_en,
    input  rvv_pkg::sew_e          new_sew,
    input  wire  [`RVV_XLEN-1:0]   avl,
    input  wire                    avl_max,   // rs1 field was x0
    output rvv_pkg::sew_e          sew,
    output logic [`RVV_XLEN-1:0]   vl,
    output logic [`RVV_DW_B-1:0]   vl_be
);

    logic [`RVV_XLEN-1:0] vlmax;

    // elements per register at the requested SEW
    assign vlmax = `RVV_XLEN'(`RVV_DW_B) >> new_sew;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sew <= rvv_pkg::SEW_8;
            vl  <= '0;
        end else if (cfg_en) begin
            sew <= new_sew;
            vl  <= (avl_max || avl > vlmax) ? vlmax : avl;
        end
    end

    // byte i belongs to element i >> sew
    always_comb begin
        for (int i = 0; i < `RVV_DW_B; i++) begin
            vl_be[i] = (`RVV_XLEN'(i >> sew) < vl);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rvv_scoreboard.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_defs.svh"

module rvv_scoreboard (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           set_en,    // instruction leaves decode
    input  wire [`RVV_REG_ADDR_WIDTH-1:0] set_addr,
    input  wire                           clr_en,    // write port retires
    input  wire [`RVV_REG_ADDR_WIDTH-1:0] clr_addr,
    input  wire [`RVV_REG_ADDR_WIDTH-1:0] chk1,
    input  wire [`RVV_REG_ADDR_WIDTH-1:0] chk2,
    input  wire                           chk1_en,
    input  wire                           chk2_en,
    output logic                          hazard
);

    logic [`RVV_NUM_VEC-1:0] pend;
    logic [`RVV_NUM_VEC-1:0] set_vec;
    logic [`RVV_NUM_VEC-1:0] clr_vec;
    logic [`RVV_NUM_VEC-1:0] live;

    assign set_vec = set_en ? (`RVV_NUM_VEC'(1) << set_addr) : '0;
    assign clr_vec = clr_en ? (`RVV_NUM_VEC'(1) << clr_addr) : '0;

    // a register written this edge no longer blocks the reader
    assign live   = pend & ~clr_vec;
    assign hazard = (chk1_en & live[chk1]) | (chk2_en & live[chk2]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend <= '0;
        end else begin
            pend <= live | set_vec;  // a new writer of the same reg keeps it pending
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rvv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_defs.svh"

module rvv_regfile (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire [`RVV_REG_ADDR_WIDTH-1:0] rd_addr_1,
    input  wire [`RVV_REG_ADDR_WIDTH-1:0] rd_addr_2,
    output rvv_pkg::vreg_t                rd_data_1,
    output rvv_pkg::vreg_t                rd_data_2,
    input  wire [`RVV_DW_B-1:0]           wr_en,
    input  wire [`RVV_REG_ADDR_WIDTH-1:0] wr_addr,
    input  rvv_pkg::vreg_t                wr_data
);

    rvv_pkg::vreg_t regs [`RVV_NUM_VEC];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `RVV_NUM_VEC; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < `RVV_DW_B; b++) begin
                if (wr_en[b]) regs[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
    end

    // bytes written at this edge are forwarded to the decode stage
    always_comb begin
        rd_data_1 = regs[rd_addr_1];
        rd_data_2 = regs[rd_addr_2];
        for (int b = 0; b < `RVV_DW_B; b++) begin
            if (wr_en[b] && wr_addr == rd_addr_1) rd_data_1[b*8 +: 8] = wr_data[b*8 +: 8];
            if (wr_en[b] && wr_addr == rd_addr_2) rd_data_2[b*8 +: 8] = wr_data[b*8 +: 8];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rvv_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_defs.svh"

module rvv_alu (
    input  rvv_pkg::exec_req_t req,
    output rvv_pkg::vreg_t     result
);

    rvv_pkg::vreg_t op1;
    rvv_pkg::vreg_t sum;
    logic [2:0]     elem_mask;  // byte index bits inside one element
    logic           is_sub;

    assign is_sub    = (req.fn == rvv_pkg::FN_SUB);
    assign elem_mask = 3'((3'd1 << req.sew) - 3'd1);

    // operand 1: vs1, or the scalar replicated at SEW
    always_comb begin
        if (req.kind == rvv_pkg::SRC_VV) begin
            op1 = req.vs1;
        end else begin
            case (req.sew)
                rvv_pkg::SEW_8:  op1 = {`RVV_DW_B{req.scalar[7:0]}};
                rvv_pkg::SEW_16: op1 = {(`RVV_DW_B/2){req.scalar[15:0]}};
                rvv_pkg::SEW_32: op1 = {(`RVV_DW_B/4){req.scalar[31:0]}};
                default:         op1 = {{(`RVV_VLEN-`RVV_XLEN){req.scalar[`RVV_XLEN-1]}},
                                        req.scalar};
            endcase
        end
    end

    // byte-serial carry chain, cut at every element boundary
    always_comb begin : addsub
        logic [8:0] part;
        logic [7:0] rhs;
        logic       carry;
        carry = 1'b0;
        for (int b = 0; b < `RVV_DW_B; b++) begin
            if ((3'(b) & elem_mask) == 3'd0) begin
                carry = is_sub;  // +1 of the two's complement
            end
            rhs  = is_sub ? ~op1[b*8 +: 8] : op1[b*8 +: 8];
            part = {1'b0, req.vs2[b*8 +: 8]} + {1'b0, rhs} + {8'd0, carry};
            sum[b*8 +: 8] = part[7:0];
            carry = part[8];
        end
    end

    always_comb begin
        case (req.fn)
            rvv_pkg::FN_AND: result = req.vs2 & op1;
            rvv_pkg::FN_OR:  result = req.vs2 | op1;
            rvv_pkg::FN_XOR: result = req.vs2 ^ op1;
            default:         result = sum;  // add, and vs2 - op1
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rvv_mem_port.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_defs.svh"

module rvv_mem_port (
    input  wire                             clk,
    input  wire                             rst_n,
    input  rvv_pkg::exec_req_t              req,
    input  wire  [`RVV_MEM_ADDR_WIDTH-1:0]  addr,
    input  rvv_pkg::vreg_t                  mem_port_in,
    input  wire                             mem_port_valid_in,
    output logic                            mem_port_ready_out,
    output rvv_pkg::vreg_t                  mem_port_out,
    output logic [`RVV_MEM_ADDR_WIDTH-1:0]  mem_port_addr_out,
    output logic                            mem_port_valid_out,
    output logic                            ld_done,
    output rvv_pkg::vreg_t                  ld_data
);

    logic                           is_load;
    logic                           is_store;
    logic [`RVV_MEM_ADDR_WIDTH-1:0] st_addr_q;

    assign is_load  = (req.cls == rvv_pkg::CLS_LOAD);
    assign is_store = (req.cls == rvv_pkg::CLS_STORE);

    // a load right behind a store waits out the store pulse
    assign mem_port_ready_out = is_load & ~mem_port_valid_out;
    assign ld_done            = mem_port_ready_out & mem_port_valid_in;
    assign ld_data            = mem_port_in;
    assign mem_port_addr_out  = mem_port_valid_out ? st_addr_q : addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_port_valid_out <= 1'b0;
        end else begin
            mem_port_valid_out <= is_store;  // one cycle, exec never holds a store
        end
    end

    always_ff @(posedge clk) begin
        if (is_store) begin
            mem_port_out <= req.vs2;  // vs3 was read on port 2
            st_addr_q    <= addr;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rvv_proc_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_defs.svh"

module rvv_proc_top (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire  [`RVV_INSN_WIDTH-1:0]      insn_in,
    input  wire                             insn_valid,
    input  wire  [`RVV_XLEN-1:0]            vexrv_data_in_1,
    input  wire  [`RVV_XLEN-1:0]            vexrv_data_in_2,
    input  wire  [`RVV_VLEN-1:0]            mem_port_in,
    input  wire                             mem_port_valid_in,
    output logic                            mem_port_ready_out,
    output logic [`RVV_VLEN-1:0]            mem_port_out,
    output logic [`RVV_MEM_ADDR_WIDTH-1:0]  mem_port_addr_out,
    output logic                            mem_port_valid_out,
    output logic                            proc_rdy,
    output logic [`RVV_XLEN-1:0]            vexrv_data_out,
    output logic                            vexrv_valid_out
);

    logic [`RVV_INSN_WIDTH-1:0]     insn_q;    // decode register, zero is a bubble
    logic [`RVV_XLEN-1:0]           data1_q;
    logic                           run_q;
    rvv_pkg::dec_insn_t             dec;
    logic                           hazard;
    logic                           dec_hold;
    logic                           ld_wait;
    logic                           ld_done;
    logic                           chk1_en;
    logic                           chk2_en;
    logic                           set_en;
    logic [`RVV_REG_ADDR_WIDTH-1:0] rd_addr_2;
    rvv_pkg::vreg_t                 rd_data_1;
    rvv_pkg::vreg_t                 rd_data_2;
    rvv_pkg::sew_e                  sew;
    logic [`RVV_XLEN-1:0]           vl;
    logic [`RVV_DW_B-1:0]           vl_be;
    rvv_pkg::exec_req_t             new_req;
    rvv_pkg::exec_req_t             ex_req;
    logic [`RVV_MEM_ADDR_WIDTH-1:0] ex_addr;
    rvv_pkg::vreg_t                 alu_result;
    rvv_pkg::vreg_t                 ld_data;
    logic                           retire_alu;
    logic [`RVV_DW_B-1:0]           wr_en;
    rvv_pkg::vreg_t                 wr_data;

    // stall control
    assign ld_wait  = (ex_req.cls == rvv_pkg::CLS_LOAD) & ~ld_done;
    assign dec_hold = ld_wait | hazard;
    assign proc_rdy = run_q & ~dec_hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            insn_q <= '0;
        end else begin
            run_q <= 1'b1;
            if (!dec_hold) insn_q <= (insn_valid && proc_rdy) ? insn_in : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (insn_valid && proc_rdy) data1_q <= vexrv_data_in_1;  // AVL, rs1 or address
    end

    rvv_decoder u_decoder (
        .insn (insn_q),
        .dec  (dec)
    );

    // a store reads vs3 through port 2
    assign rd_addr_2 = (dec.cls == rvv_pkg::CLS_STORE) ? dec.dest : dec.src2;
    assign chk1_en   = (dec.cls == rvv_pkg::CLS_ALU) && (dec.kind == rvv_pkg::SRC_VV);
    assign chk2_en   = (dec.cls == rvv_pkg::CLS_ALU) || (dec.cls == rvv_pkg::CLS_STORE);
    assign set_en    = !dec_hold &&
                       (dec.cls == rvv_pkg::CLS_ALU || dec.cls == rvv_pkg::CLS_LOAD);

    rvv_scoreboard u_scoreboard (
        .clk      (clk),
        .rst_n    (rst_n),
        .set_en   (set_en),
        .set_addr (dec.dest),
        .clr_en   (retire_alu | ld_done),
        .clr_addr (ex_req.dest),
        .chk1     (dec.src1),
        .chk2     (rd_addr_2),
        .chk1_en  (chk1_en),
        .chk2_en  (chk2_en),
        .hazard   (hazard)
    );

    rvv_cfg_unit u_cfg (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_en  (!dec_hold && dec.cls == rvv_pkg::CLS_CFG),
        .new_sew (dec.sew),
        .avl     (data1_q),
        .avl_max (dec.rs1_zero),
        .sew     (sew),
        .vl      (vl),
        .vl_be   (vl_be)
    );

    rvv_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_1 (dec.src1),
        .rd_addr_2 (rd_addr_2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .wr_en     (wr_en),
        .wr_addr   (ex_req.dest),
        .wr_data   (wr_data)
    );

    always_comb begin
        new_req.cls    = dec_hold ? rvv_pkg::CLS_NONE : dec.cls;  // bubble on hold
        new_req.fn     = dec.fn;
        new_req.kind   = dec.kind;
        new_req.dest   = dec.dest;
        new_req.sew    = sew;
        new_req.vs1    = rd_data_1;
        new_req.vs2    = rd_data_2;
        new_req.scalar = (dec.kind == rvv_pkg::SRC_VI) ?
                         {{(`RVV_XLEN-5){dec.src1[4]}}, dec.src1} : data1_q;
        new_req.be     = vl_be;
    end

    // execute register, held only by a waiting load
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_req.cls <= rvv_pkg::CLS_NONE;
        end else if (!ld_wait) begin
            ex_req <= new_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!ld_wait) ex_addr <= data1_q;
    end

    rvv_alu u_alu (
        .req    (ex_req),
        .result (alu_result)
    );

    rvv_mem_port u_mem_port (
        .clk                (clk),
        .rst_n              (rst_n),
        .req                (ex_req),
        .addr               (ex_addr),
        .mem_port_in        (mem_port_in),
        .mem_port_valid_in  (mem_port_valid_in),
        .mem_port_ready_out (mem_port_ready_out),
        .mem_port_out       (mem_port_out),
        .mem_port_addr_out  (mem_port_addr_out),
        .mem_port_valid_out (mem_port_valid_out),
        .ld_done            (ld_done),
        .ld_data            (ld_data)
    );

    // write port: tail-masked ALU result, or the whole load beat
    assign retire_alu = (ex_req.cls == rvv_pkg::CLS_ALU);
    assign wr_en      = ld_done ? '1 : (retire_alu ? ex_req.be : '0);
    assign wr_data    = ld_done ? ld_data : alu_result;

    // vsetvli response, vl already updated one edge earlier
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vexrv_valid_out <= 1'b0;
        end else begin
            vexrv_valid_out <= (ex_req.cls == rvv_pkg::CLS_CFG);
        end
    end

    always_ff @(posedge clk) begin
        if (ex_req.cls == rvv_pkg::CLS_CFG) vexrv_data_out <= vl;
    end

endmodule

`default_nettype wire

// ==== verification/rvv_proc_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvv_proc_chk (
    input wire clk,
    input wire rst_n,
    input wire proc_rdy,
    input wire vexrv_valid_out,
    input wire mem_port_valid_out,
    input wire mem_port_ready_out,
    input wire mem_port_valid_in
);

    // strobes settle low one edge after rst_n is seen low
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !(proc_rdy || vexrv_valid_out || mem_port_valid_out || mem_port_ready_out))
        else $error("strobe output high while rst_n is low");

    // a waiting load keeps its request up until the beat arrives
    ready_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_port_ready_out && !mem_port_valid_in |=> mem_port_ready_out)
        else $error("mem_port_ready_out dropped before mem_port_valid_in was seen");

    port_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_port_ready_out && mem_port_valid_out))
        else $error("load request and store pulse on the memory port in the same cycle");

endmodule

`default_nettype wire

// ==== verification/rvv_proc_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rvv_defs.svh"

module rvv_proc_tb;

    localparam int NUM_INSNS      = 300;
    localparam int TIMEOUT_CYCLES = NUM_INSNS * 12 + 200;

    logic                           clk;
    logic                           rst_n;
    logic [`RVV_INSN_WIDTH-1:0]     insn_in;
    logic                           insn_valid;
    logic [`RVV_XLEN-1:0]           vexrv_data_in_1;
    logic [`RVV_XLEN-1:0]           vexrv_data_in_2;
    rvv_pkg::vreg_t                 mem_port_in;
    logic                           mem_port_valid_in;
    logic                           mem_port_ready_out;
    rvv_pkg::vreg_t                 mem_port_out;
    logic [`RVV_MEM_ADDR_WIDTH-1:0] mem_port_addr_out;
    logic                           mem_port_valid_out;
    logic                           proc_rdy;
    logic [`RVV_XLEN-1:0]           vexrv_data_out;
    logic                           vexrv_valid_out;

    integer seed = 32'h72f837db;

    // architectural model, registers 0 to 7 only
    rvv_pkg::vreg_t                 model_regs [8];
    int                             model_sew;
    int                             model_vl;
    logic [`RVV_XLEN-1:0]           vl_exp_q [$];
    rvv_pkg::vreg_t                 st_data_q [$];
    logic [`RVV_MEM_ADDR_WIDTH-1:0] st_addr_q [$];

    int vl_errs = 0;
    int vreg_errs = 0;
    int addr_errs = 0;
    int other_errs = 0;
    int cycle_cnt = 0;
    int stall_cycles = 0;
    int accepted = 0;
    int n_vl = 0;
    int n_st = 0;

    rvv_proc_top dut_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .insn_in            (insn_in),
        .insn_valid         (insn_valid),
        .vexrv_data_in_1    (vexrv_data_in_1),
        .vexrv_data_in_2    (vexrv_data_in_2),
        .mem_port_in        (mem_port_in),
        .mem_port_valid_in  (mem_port_valid_in),
        .mem_port_ready_out (mem_port_ready_out),
        .mem_port_out       (mem_port_out),
        .mem_port_addr_out  (mem_port_addr_out),
        .mem_port_valid_out (mem_port_valid_out),
        .proc_rdy           (proc_rdy),
        .vexrv_data_out     (vexrv_data_out),
        .vexrv_valid_out    (vexrv_valid_out)
    );

    bind rvv_proc_top rvv_proc_chk chk_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .proc_rdy           (proc_rdy),
        .vexrv_valid_out    (vexrv_valid_out),
        .mem_port_valid_out (mem_port_valid_out),
        .mem_port_ready_out (mem_port_ready_out),
        .mem_port_valid_in  (mem_port_valid_in)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic logic [2:0] rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[2:0];
    endfunction

    // memory contents seen by loads, every address bit matters
    function automatic rvv_pkg::vreg_t mem_word(input logic [31:0] addr);
        return {addr * 32'h9e3779b9, addr ^ 32'hc3a55a3c};
    endfunction

    function automatic logic [31:0] enc_cfg(input logic [1:0] sew, input logic [4:0] rs1);
        return {7'd0, sew, 3'd0, rs1, `RVV_CFG, 5'd1, `RVV_OPC_OP};  // vlmul 0
    endfunction

    function automatic logic [31:0] enc_alu(input int fn, input int kind, input logic [4:0] vs2,
                                            input logic [4:0] src1, input logic [4:0] vd);
        logic [5:0] f6;
        logic [2:0] f3;
        case (fn)
            0:       f6 = `RVV_F6_ADD;
            1:       f6 = `RVV_F6_SUB;
            2:       f6 = `RVV_F6_AND;
            3:       f6 = `RVV_F6_OR;
            default: f6 = `RVV_F6_XOR;
        endcase
        f3 = (kind == 0) ? `RVV_IVV : ((kind == 1) ? `RVV_IVX : `RVV_IVI);
        return {f6, 1'b1, vs2, src1, f3, vd, `RVV_OPC_OP};
    endfunction

    // unit-stride whole register, 64-bit width
    function automatic logic [31:0] enc_mem(input logic [6:0] opc, input logic [4:0] vreg);
        return {3'd0, 1'b0, 2'd0, 1'b1, 5'b01000, 5'd10, 3'b111, vreg, opc};
    endfunction

    // reference result element by element, tail elements keep the old value
    function automatic rvv_pkg::vreg_t alu_model(input int fn, input rvv_pkg::vreg_t old,
            input rvv_pkg::vreg_t vs2, input rvv_pkg::vreg_t vs1, input bit use_scalar,
            input logic [63:0] s64, input int sew_code, input int vl_n);
        int             ew;
        int             ne;
        logic [63:0]    mask;
        logic [63:0]    a;
        logic [63:0]    b;
        logic [63:0]    r;
        rvv_pkg::vreg_t res;
        ew   = 8 << sew_code;
        ne   = 8 >> sew_code;
        mask = (ew == 64) ? 64'hffff_ffff_ffff_ffff : ((64'd1 << ew) - 64'd1);
        res  = old;
        for (int e = 0; e < ne && e < vl_n; e++) begin
            a = (vs2 >> (e * ew)) & mask;
            b = use_scalar ? (s64 & mask) : ((vs1 >> (e * ew)) & mask);
            case (fn)
                0:       r = a + b;
                1:       r = a - b;  // vs2 minus operand 1
                2:       r = a & b;
                3:       r = a | b;
                default: r = a ^ b;
            endcase
            res = (res & ~(mask << (e * ew))) | ((r & mask) << (e * ew));
        end
        return res;
    endfunction

    task automatic check_vl(input string name, input logic [`RVV_XLEN-1:0] exp_vl,
                            input logic [`RVV_XLEN-1:0] act_vl);
        if (act_vl !== exp_vl) begin
            vl_errs++;
            $display("Error %s: expected %0d, actual %0d", name, exp_vl, act_vl);
        end
    endtask

    task automatic check_vreg(input string name, input rvv_pkg::vreg_t exp_val,
                              input rvv_pkg::vreg_t act_val);
        if (act_val !== exp_val) begin
            vreg_errs++;
            $display("Error %s: expected %h, actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic check_addr(input string name, input logic [`RVV_MEM_ADDR_WIDTH-1:0] exp_addr,
                              input logic [`RVV_MEM_ADDR_WIDTH-1:0] act_addr);
        if (act_addr !== exp_addr) begin
            addr_errs++;
            $display("Error %s: expected %h, actual %h", name, exp_addr, act_addr);
        end
    endtask

    // holds the instruction until proc_rdy takes it
    task automatic send_insn(input logic [31:0] insn, input logic [31:0] data1);
        insn_in         = insn;
        insn_valid      = 1'b1;
        vexrv_data_in_1 = data1;
        vexrv_data_in_2 = $random(seed);
        @(negedge clk);
        while (!proc_rdy) @(negedge clk);
        @(posedge clk);  // acceptance edge
        #10;
        insn_valid = 1'b0;
        accepted++;
    endtask

    task automatic do_store(input logic [2:0] r, input logic [31:0] addr);
        send_insn(enc_mem(`RVV_OPC_ST, {2'b0, r}), addr);
        st_data_q.push_back(model_regs[r]);
        st_addr_q.push_back(addr);
    endtask

    // load responder, 0 to 5 cycles of latency
    initial begin : mem_responder
        int wait_cnt;
        wait_cnt          = -1;
        mem_port_in       = '0;
        mem_port_valid_in = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            mem_port_valid_in = 1'b0;
            if (rst_n && mem_port_ready_out) begin
                if (wait_cnt < 0) wait_cnt = rand_below(6);
                if (wait_cnt == 0) begin
                    mem_port_valid_in = 1'b1;
                    mem_port_in       = mem_word(mem_port_addr_out);
                end
                wait_cnt--;
            end
        end
    end

    // outputs are registered, so mid-cycle sampling is safe
    always @(negedge clk) begin
        if (rst_n && vexrv_valid_out) begin
            if (vl_exp_q.size() == 0) begin
                other_errs++;
                $display("vsetvli response seen with no vsetvli outstanding");
            end else begin
                check_vl($sformatf("vsetvli %0d", n_vl), vl_exp_q.pop_front(), vexrv_data_out);
            end
            n_vl++;
        end
        if (rst_n && mem_port_valid_out) begin
            if (st_data_q.size() == 0) begin
                other_errs++;
                $display("store pulse seen with no store outstanding");
            end else begin
                check_vreg($sformatf("store %0d data", n_st), st_data_q.pop_front(), mem_port_out);
                check_addr($sformatf("store %0d addr", n_st), st_addr_q.pop_front(),
                           mem_port_addr_out);
            end
            n_st++;
        end
        if (rst_n && insn_valid && !proc_rdy && accepted > 0) stall_cycles++;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin : watchdog
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        int          pick;
        int          fn;
        int          kind;
        int          sew_code;
        int          end_errs;
        logic [2:0]  vd;
        logic [2:0]  va;
        logic [2:0]  vb;
        logic [2:0]  last_ld;
        logic [4:0]  src1;
        logic [31:0] data1;
        logic [63:0] s64;
        rst_n           = 1'b0;
        insn_in         = '0;
        insn_valid      = 1'b0;
        vexrv_data_in_1 = '0;
        vexrv_data_in_2 = '0;
        for (int i = 0; i < 8; i++) model_regs[i] = '0;
        model_sew = 0;
        model_vl  = 0;
        last_ld   = 3'd0;
        end_errs  = 0;
        repeat (10) @(posedge clk);
        #10;
        rst_n = 1'b1;

        for (int n = 0; n < NUM_INSNS; n++) begin
            pick = (n == 0) ? 0 : rand_below(20);
            if (pick < 3) begin
                sew_code = rand_below(4);
                src1     = (rand_below(4) == 0) ? 5'd0 : 5'(1 + rand_below(31));
                data1    = 32'(rand_below(12));  // AVL around VLMAX
                send_insn(enc_cfg(2'(sew_code), src1), data1);
                model_sew = sew_code;
                model_vl  = (src1 == 5'd0 || data1 > (8 >> sew_code)) ? (8 >> sew_code)
                                                                      : int'(data1);
                vl_exp_q.push_back(32'(model_vl));
            end else if (pick < 13) begin
                fn    = rand_below(5);
                kind  = rand_below(3);
                vd    = rand_reg();
                va    = rand_reg();
                vb    = (rand_below(2) == 0) ? last_ld : rand_reg();
                data1 = $random(seed);
                src1  = (kind == 0) ? {2'b0, va} : 5'(rand_below(32));
                s64   = (kind == 2) ? {{59{src1[4]}}, src1} : {{32{data1[31]}}, data1};
                send_insn(enc_alu(fn, kind, {2'b0, vb}, src1, {2'b0, vd}), data1);
                model_regs[vd] = alu_model(fn, model_regs[vd], model_regs[vb], model_regs[va],
                                           kind != 0, s64, model_sew, model_vl);
            end else if (pick < 16) begin
                vd         = rand_reg();
                data1      = $random(seed);
                data1[2:0] = 3'd0;
                send_insn(enc_mem(`RVV_OPC_LD, {2'b0, vd}), data1);
                model_regs[vd] = mem_word(data1);
                last_ld        = vd;
            end else begin
                va    = (rand_below(2) == 0) ? last_ld : rand_reg();
                data1 = $random(seed);
                do_store(va, data1);
            end
            if (rand_below(8) == 0) begin  // idle host cycle
                @(posedge clk);
                #10;
            end
        end

        // dump the whole register state through the store path
        for (int r = 0; r < 8; r++) begin
            do_store(3'(r), 32'h0000_1000 + 32'(r * 8));
        end
        while (vl_exp_q.size() != 0 || st_data_q.size() != 0) @(posedge clk);

        if (stall_cycles == 0) begin
            end_errs++;
            $display("proc_rdy never dropped while an instruction was offered");
        end
        $display("errors: vl %0d, vreg %0d, addr %0d, other %0d",
                 vl_errs, vreg_errs, addr_errs, other_errs + end_errs);
        if (vl_errs + vreg_errs + addr_errs + other_errs + end_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rvv_proc.f ====
+incdir+verilog
verilog/rvv_pkg.sv
verilog/rvv_decoder.sv
verilog/rvv_cfg_unit.sv
verilog/rvv_scoreboard.sv
verilog/rvv_regfile.sv
verilog/rvv_alu.sv
verilog/rvv_mem_port.sv
verilog/rvv_proc_top.sv
verification/rvv_proc_chk.sv
verification/rvv_proc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the rvv_proc testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f rvv_proc.f --top-module rvv_proc_tb -o rvv_proc_sim \
    && ./obj_dir/rvv_proc_sim | tee /dev/stderr | grep -x "Simulation passed" > /dev/null \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }
